// File: src/l2_bus_pkg.sv
/*
 * L2 memory port shared definitions
 * Bus widths, response codes and arbiter states
 */
package l2_bus_pkg;

    // Byte address, data and strobe widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // Response code width and values
    localparam int RESP_W = 2;
    localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
    localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

    // Arbiter FSM
    typedef enum logic [2:0] {
        ARB_IDLE,
        ARB_AR,
        ARB_R,
        ARB_AW,
        ARB_W,
        ARB_B,
        ARB_RESP
    } arb_state_e;

endpackage

// File: src/l1_port_buffer.sv
/*
 * L1 port buffer
 * Holds one request for the arbiter and one response for the requester
 */
module l1_port_buffer
    import l2_bus_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_nrst,
    input  logic              i_req_valid,
    input  logic              i_req_write,
    input  logic [ADDR_W-1:0] i_req_addr,
    input  logic [DATA_W-1:0] i_req_wdata,
    input  logic [STRB_W-1:0] i_req_strb,
    output logic              o_req_ready,
    output logic              o_rsp_valid,
    output logic [DATA_W-1:0] o_rsp_rdata,
    output logic [RESP_W-1:0] o_rsp_resp,
    input  logic              i_rsp_ready,
    output logic              o_pend_valid,
    output logic              o_pend_write,
    output logic [ADDR_W-1:0] o_pend_addr,
    output logic [DATA_W-1:0] o_pend_wdata,
    output logic [STRB_W-1:0] o_pend_strb,
    input  logic              i_grant,
    input  logic              i_ret_valid,
    input  logic [DATA_W-1:0] i_ret_rdata,
    input  logic [RESP_W-1:0] i_ret_resp,
    output logic              o_ret_ready
);

    logic req_full;
    logic rsp_full;
    logic req_hs;
    logic ret_hs;

    // New requests only while both registers are free
    assign o_req_ready = ~req_full & ~rsp_full;
    assign req_hs      = i_req_valid & o_req_ready;
    assign o_ret_ready = ~rsp_full;
    assign ret_hs      = i_ret_valid & o_ret_ready;

    // A waiting response hides the request, so the arbiter never stalls on this slot
    assign o_pend_valid = req_full & ~rsp_full;
    assign o_rsp_valid  = rsp_full;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            req_full <= 1'b0;
            rsp_full <= 1'b0;
        end else begin
            if (req_hs) begin
                req_full <= 1'b1;
            end else if (i_grant) begin
                req_full <= 1'b0;
            end
            if (ret_hs) begin
                rsp_full <= 1'b1;
            end else if (i_rsp_ready) begin
                rsp_full <= 1'b0;
            end
        end
    end

    // Payload registers
    always_ff @(posedge i_clk) begin
        if (req_hs) begin
            o_pend_write <= i_req_write;
            o_pend_addr  <= i_req_addr;
            o_pend_wdata <= i_req_wdata;
            o_pend_strb  <= i_req_strb;
        end
        if (ret_hs) begin
            o_rsp_rdata <= i_ret_rdata;
            o_rsp_resp  <= i_ret_resp;
        end
    end

    // Arbiter must only grant a slot that holds a request
    a_grant_needs_req: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_grant |-> req_full);

endmodule

// File: src/l2_arbiter.sv
/*
 * L2 arbiter
 * Picks one pending slot, writes first then lowest index, and replays it on the memory bus
 */
module l2_arbiter
    import l2_bus_pkg::*;
#(
    parameter int N_SLOTS = 2
) (
    input  logic                        i_clk,
    input  logic                        i_nrst,
    input  logic [N_SLOTS-1:0]          i_pend_valid,
    input  logic [N_SLOTS-1:0]          i_pend_write,
    input  logic [N_SLOTS*ADDR_W-1:0]   i_pend_addr,
    input  logic [N_SLOTS*DATA_W-1:0]   i_pend_wdata,
    input  logic [N_SLOTS*STRB_W-1:0]   i_pend_strb,
    output logic [N_SLOTS-1:0]          o_grant,
    output logic [N_SLOTS-1:0]          o_ret_valid,
    output logic [N_SLOTS*DATA_W-1:0]   o_ret_rdata,
    output logic [N_SLOTS*RESP_W-1:0]   o_ret_resp,
    input  logic [N_SLOTS-1:0]          i_ret_ready,
    output logic                        o_aw_valid,
    output logic [ADDR_W-1:0]           o_aw_addr,
    input  logic                        i_aw_ready,
    output logic                        o_w_valid,
    output logic [DATA_W-1:0]           o_w_data,
    output logic [STRB_W-1:0]           o_w_strb,
    input  logic                        i_w_ready,
    input  logic                        i_b_valid,
    input  logic [RESP_W-1:0]           i_b_resp,
    output logic                        o_b_ready,
    output logic                        o_ar_valid,
    output logic [ADDR_W-1:0]           o_ar_addr,
    input  logic                        i_ar_ready,
    input  logic                        i_r_valid,
    input  logic [DATA_W-1:0]           i_r_data,
    input  logic [RESP_W-1:0]           i_r_resp,
    output logic                        o_r_ready
);

    localparam int IDX_W = (N_SLOTS > 1) ? $clog2(N_SLOTS) : 1;

    arb_state_e          state;
    logic [IDX_W-1:0]    src_q;
    logic [ADDR_W-1:0]   addr_q;
    logic [DATA_W-1:0]   wdata_q;
    logic [STRB_W-1:0]   strb_q;
    logic [DATA_W-1:0]   rdata_q;
    logic [RESP_W-1:0]   resp_q;
    logic [N_SLOTS-1:0]  cand;
    logic [IDX_W-1:0]    win_idx;

    // Writes take priority, lowest index inside each class
    always_comb begin
        cand    = (|(i_pend_valid & i_pend_write)) ? (i_pend_valid & i_pend_write) : i_pend_valid;
        win_idx = '0;
        for (int i = N_SLOTS - 1; i >= 0; i--) begin
            if (cand[i]) begin
                win_idx = IDX_W'(i);
            end
        end
    end

    // Bus channel drive follows the state
    assign o_aw_valid = (state == ARB_AW);
    assign o_w_valid  = (state == ARB_AW) || (state == ARB_W);
    assign o_b_ready  = (state == ARB_B);
    assign o_ar_valid = (state == ARB_AR);
    assign o_r_ready  = (state == ARB_R);
    assign o_aw_addr  = addr_q;
    assign o_ar_addr  = addr_q;
    assign o_w_data   = wdata_q;
    assign o_w_strb   = strb_q;

    // Data is broadcast, only the source slot sees valid
    assign o_ret_valid = (state == ARB_RESP) ? (N_SLOTS'(1) << src_q) : '0;
    assign o_ret_rdata = {N_SLOTS{rdata_q}};
    assign o_ret_resp  = {N_SLOTS{resp_q}};

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state   <= ARB_IDLE;
            o_grant <= '0;
            src_q   <= '0;
        end else begin
            o_grant <= '0;
            case (state)
                ARB_IDLE: begin
                    if (|i_pend_valid) begin
                        o_grant <= N_SLOTS'(1) << win_idx;
                        src_q   <= win_idx;
                        state   <= i_pend_write[win_idx] ? ARB_AW : ARB_AR;
                    end
                end
                ARB_AR: begin
                    if (i_ar_ready) begin
                        state <= ARB_R;
                    end
                end
                ARB_R: begin
                    if (i_r_valid) begin
                        state <= ARB_RESP;
                    end
                end
                ARB_AW: begin
                    // Address taken alone leaves the data to be offered on its own
                    if (i_aw_ready) begin
                        state <= i_w_ready ? ARB_B : ARB_W;
                    end
                end
                ARB_W: begin
                    if (i_w_ready) begin
                        state <= ARB_B;
                    end
                end
                ARB_B: begin
                    if (i_b_valid) begin
                        state <= ARB_RESP;
                    end
                end
                ARB_RESP: begin
                    if (i_ret_ready[src_q]) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Request and response payload
    always_ff @(posedge i_clk) begin
        if (state == ARB_IDLE) begin
            addr_q  <= i_pend_addr[win_idx*ADDR_W +: ADDR_W];
            wdata_q <= i_pend_wdata[win_idx*DATA_W +: DATA_W];
            strb_q  <= i_pend_strb[win_idx*STRB_W +: STRB_W];
        end
        if (state == ARB_R && i_r_valid) begin
            rdata_q <= i_r_data;
            resp_q  <= i_r_resp;
        end
        if (state == ARB_B && i_b_valid) begin
            rdata_q <= '0;
            resp_q  <= i_b_resp;
        end
    end

    a_grant_onehot: assert property (@(posedge i_clk) disable iff (!i_nrst)
        $onehot0(o_grant));

    // Only one transaction reaches the memory at a time
    a_aw_ar_excl: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !(o_aw_valid && o_ar_valid));

endmodule

// File: src/l2_sram.sv
/*
 * L2 word memory
 * Serves the memory bus with byte strobes, a range check and wait states
 */
module l2_sram
    import l2_bus_pkg::*;
#(
    parameter int MEM_WORDS = 256
) (
    input  logic              i_clk,
    input  logic              i_nrst,
    input  logic              i_aw_valid,
    input  logic [ADDR_W-1:0] i_aw_addr,
    output logic              o_aw_ready,
    input  logic              i_w_valid,
    input  logic [DATA_W-1:0] i_w_data,
    input  logic [STRB_W-1:0] i_w_strb,
    output logic              o_w_ready,
    output logic              o_b_valid,
    output logic [RESP_W-1:0] o_b_resp,
    input  logic              i_b_ready,
    input  logic              i_ar_valid,
    input  logic [ADDR_W-1:0] i_ar_addr,
    output logic              o_ar_ready,
    output logic              o_r_valid,
    output logic [DATA_W-1:0] o_r_data,
    output logic [RESP_W-1:0] o_r_resp,
    input  logic              i_r_ready
);

    localparam int WAIT_CYCLES = 1;
    localparam int WORD_W      = $clog2(MEM_WORDS);
    localparam int unsigned LIMIT = MEM_WORDS * 4;

    typedef enum logic [2:0] {S_RESET, S_IDLE, S_WDATA, S_WAIT, S_RESP} sram_state_e;

    sram_state_e       state;
    logic [1:0]        cnt;
    logic              wr_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic [STRB_W-1:0] strb_q;
    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic              aw_hs;
    logic              w_hs;
    logic              ar_hs;
    logic              acc;
    logic              in_range;
    logic [WORD_W-1:0] idx;

    assign o_aw_ready = (state == S_IDLE);
    assign o_ar_ready = (state == S_IDLE);
    assign o_w_ready  = (state == S_IDLE) || (state == S_WDATA);
    assign aw_hs      = i_aw_valid & o_aw_ready;
    assign w_hs       = i_w_valid & o_w_ready;
    assign ar_hs      = i_ar_valid & o_ar_ready & ~i_aw_valid;

    // Access happens on the last wait cycle from the latched request
    assign acc      = (state == S_WAIT) && (cnt == '0);
    assign in_range = (32'(addr_q) < LIMIT);
    assign idx      = addr_q[2 +: WORD_W];

    assign o_b_valid = (state == S_RESP) && wr_q;
    assign o_r_valid = (state == S_RESP) && !wr_q;
    assign o_r_resp  = o_b_resp;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state <= S_RESET;
            cnt   <= '0;
            wr_q  <= 1'b0;
        end else begin
            case (state)
                S_RESET: state <= S_IDLE;
                S_IDLE: begin
                    cnt <= 2'(WAIT_CYCLES - 1);
                    if (aw_hs) begin
                        wr_q  <= 1'b1;
                        state <= i_w_valid ? S_WAIT : S_WDATA;
                    end else if (ar_hs) begin
                        wr_q  <= 1'b0;
                        state <= S_WAIT;
                    end
                end
                S_WDATA: state <= w_hs ? S_WAIT : S_WDATA;
                S_WAIT: begin
                    cnt <= cnt - 2'd1;
                    if (cnt == '0) begin
                        state <= S_RESP;
                    end
                end
                S_RESP: begin
                    if (wr_q ? i_b_ready : i_r_ready) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (aw_hs) begin
            addr_q <= i_aw_addr;
        end else if (ar_hs) begin
            addr_q <= i_ar_addr;
        end
        if (w_hs) begin
            wdata_q <= i_w_data;
            strb_q  <= i_w_strb;
        end
        if (acc) begin
            o_b_resp <= in_range ? RESP_OKAY : RESP_SLVERR;
            o_r_data <= (in_range && !wr_q) ? mem[idx] : '0;
            if (in_range && wr_q) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (strb_q[b]) begin
                        mem[idx][8*b +: 8] <= wdata_q[8*b +: 8];
                    end
                end
            end
        end
    end

    // Write data never arrives ahead of its address
    a_no_data_first: assert property (@(posedge i_clk) disable iff (!i_nrst)
        w_hs |-> aw_hs || (state == S_WDATA));

endmodule

// File: src/l2_subsystem_top.sv
/*
 * L2 memory port top level
 * Port buffers per slot, one arbiter and the word memory
 */
module l2_subsystem_top
    import l2_bus_pkg::*;
#(
    parameter int N_SLOTS   = 2,
    parameter int MEM_WORDS = 256
) (
    input  logic                      i_clk,
    input  logic                      i_nrst,
    input  logic [N_SLOTS-1:0]        i_req_valid,
    input  logic [N_SLOTS-1:0]        i_req_write,
    input  logic [N_SLOTS*ADDR_W-1:0] i_req_addr,
    input  logic [N_SLOTS*DATA_W-1:0] i_req_wdata,
    input  logic [N_SLOTS*STRB_W-1:0] i_req_strb,
    output logic [N_SLOTS-1:0]        o_req_ready,
    output logic [N_SLOTS-1:0]        o_rsp_valid,
    output logic [N_SLOTS*DATA_W-1:0] o_rsp_rdata,
    output logic [N_SLOTS*RESP_W-1:0] o_rsp_resp,
    input  logic [N_SLOTS-1:0]        i_rsp_ready
);

    logic [N_SLOTS-1:0]        pend_valid;
    logic [N_SLOTS-1:0]        pend_write;
    logic [N_SLOTS*ADDR_W-1:0] pend_addr;
    logic [N_SLOTS*DATA_W-1:0] pend_wdata;
    logic [N_SLOTS*STRB_W-1:0] pend_strb;
    logic [N_SLOTS-1:0]        grant;
    logic [N_SLOTS-1:0]        ret_valid;
    logic [N_SLOTS*DATA_W-1:0] ret_rdata;
    logic [N_SLOTS*RESP_W-1:0] ret_resp;
    logic [N_SLOTS-1:0]        ret_ready;

    // Memory bus
    logic              aw_valid;
    logic [ADDR_W-1:0] aw_addr;
    logic              aw_ready;
    logic              w_valid;
    logic [DATA_W-1:0] w_data;
    logic [STRB_W-1:0] w_strb;
    logic              w_ready;
    logic              b_valid;
    logic [RESP_W-1:0] b_resp;
    logic              b_ready;
    logic              ar_valid;
    logic [ADDR_W-1:0] ar_addr;
    logic              ar_ready;
    logic              r_valid;
    logic [DATA_W-1:0] r_data;
    logic [RESP_W-1:0] r_resp;
    logic              r_ready;

    for (genvar i = 0; i < N_SLOTS; i++) begin : g_slot
        l1_port_buffer i_l1_port_buffer (
            .i_clk        (i_clk),
            .i_nrst       (i_nrst),
            .i_req_valid  (i_req_valid[i]),
            .i_req_write  (i_req_write[i]),
            .i_req_addr   (i_req_addr[i*ADDR_W +: ADDR_W]),
            .i_req_wdata  (i_req_wdata[i*DATA_W +: DATA_W]),
            .i_req_strb   (i_req_strb[i*STRB_W +: STRB_W]),
            .o_req_ready  (o_req_ready[i]),
            .o_rsp_valid  (o_rsp_valid[i]),
            .o_rsp_rdata  (o_rsp_rdata[i*DATA_W +: DATA_W]),
            .o_rsp_resp   (o_rsp_resp[i*RESP_W +: RESP_W]),
            .i_rsp_ready  (i_rsp_ready[i]),
            .o_pend_valid (pend_valid[i]),
            .o_pend_write (pend_write[i]),
            .o_pend_addr  (pend_addr[i*ADDR_W +: ADDR_W]),
            .o_pend_wdata (pend_wdata[i*DATA_W +: DATA_W]),
            .o_pend_strb  (pend_strb[i*STRB_W +: STRB_W]),
            .i_grant      (grant[i]),
            .i_ret_valid  (ret_valid[i]),
            .i_ret_rdata  (ret_rdata[i*DATA_W +: DATA_W]),
            .i_ret_resp   (ret_resp[i*RESP_W +: RESP_W]),
            .o_ret_ready  (ret_ready[i])
        );
    end

    l2_arbiter #(
        .N_SLOTS (N_SLOTS)
    ) i_l2_arbiter (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_pend_valid (pend_valid),
        .i_pend_write (pend_write),
        .i_pend_addr  (pend_addr),
        .i_pend_wdata (pend_wdata),
        .i_pend_strb  (pend_strb),
        .o_grant      (grant),
        .o_ret_valid  (ret_valid),
        .o_ret_rdata  (ret_rdata),
        .o_ret_resp   (ret_resp),
        .i_ret_ready  (ret_ready),
        .o_aw_valid   (aw_valid),
        .o_aw_addr    (aw_addr),
        .i_aw_ready   (aw_ready),
        .o_w_valid    (w_valid),
        .o_w_data     (w_data),
        .o_w_strb     (w_strb),
        .i_w_ready    (w_ready),
        .i_b_valid    (b_valid),
        .i_b_resp     (b_resp),
        .o_b_ready    (b_ready),
        .o_ar_valid   (ar_valid),
        .o_ar_addr    (ar_addr),
        .i_ar_ready   (ar_ready),
        .i_r_valid    (r_valid),
        .i_r_data     (r_data),
        .i_r_resp     (r_resp),
        .o_r_ready    (r_ready)
    );

    l2_sram #(
        .MEM_WORDS (MEM_WORDS)
    ) i_l2_sram (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .i_aw_valid (aw_valid),
        .i_aw_addr  (aw_addr),
        .o_aw_ready (aw_ready),
        .i_w_valid  (w_valid),
        .i_w_data   (w_data),
        .i_w_strb   (w_strb),
        .o_w_ready  (w_ready),
        .o_b_valid  (b_valid),
        .o_b_resp   (b_resp),
        .i_b_ready  (b_ready),
        .i_ar_valid (ar_valid),
        .i_ar_addr  (ar_addr),
        .o_ar_ready (ar_ready),
        .o_r_valid  (r_valid),
        .o_r_data   (r_data),
        .o_r_resp   (r_resp),
        .i_r_ready  (r_ready)
    );

endmodule

// File: tests/tb_l2_subsystem.sv
/*
 * L2 memory port testbench
 * Directed tests for two requester slots against a reference memory model
 */
module tb_l2_subsystem
    import l2_bus_pkg::*;
();

    localparam int N_SLOTS   = 2;
    localparam int MEM_WORDS = 256;
    // The tests take a few hundred cycles, so this leaves a wide margin
    localparam int MAX_CYCLES = 4000;

    logic                      i_clk;
    logic                      i_nrst;
    logic [N_SLOTS-1:0]        i_req_valid;
    logic [N_SLOTS-1:0]        i_req_write;
    logic [N_SLOTS*ADDR_W-1:0] i_req_addr;
    logic [N_SLOTS*DATA_W-1:0] i_req_wdata;
    logic [N_SLOTS*STRB_W-1:0] i_req_strb;
    logic [N_SLOTS-1:0]        o_req_ready;
    logic [N_SLOTS-1:0]        o_rsp_valid;
    logic [N_SLOTS*DATA_W-1:0] o_rsp_rdata;
    logic [N_SLOTS*RESP_W-1:0] o_rsp_resp;
    logic [N_SLOTS-1:0]        i_rsp_ready;

    logic [31:0]       rng_state;
    logic [DATA_W-1:0] ref_mem [MEM_WORDS];
    logic [ADDR_W-1:0] known_addr;
    int                cycles = 0;
    int                errors = 0;
    int                checks = 0;

    l2_subsystem_top #(
        .N_SLOTS   (N_SLOTS),
        .MEM_WORDS (MEM_WORDS)
    ) i_l2_subsystem_top (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_req_valid (i_req_valid),
        .i_req_write (i_req_write),
        .i_req_addr  (i_req_addr),
        .i_req_wdata (i_req_wdata),
        .i_req_strb  (i_req_strb),
        .o_req_ready (o_req_ready),
        .o_rsp_valid (o_rsp_valid),
        .o_rsp_rdata (o_rsp_rdata),
        .o_rsp_resp  (o_rsp_resp),
        .i_rsp_ready (i_rsp_ready)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, a response never arrived", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_word();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // Word aligned, always inside the memory
    function automatic logic [ADDR_W-1:0] rand_addr();
        logic [31:0] r;
        r = rand_word();
        return ADDR_W'((r % MEM_WORDS) * 4);
    endfunction

    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
                                                      input logic [DATA_W-1:0] new_w,
                                                      input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] res;
        res = old_w;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_condition(input logic cond, input string msg);
        checks++;
        assert (cond === 1'b1) else begin
            errors++;
            $display("ERROR at t=%0t: %s", $time, msg);
        end
    endtask

    task automatic drive_request(input int slot, input logic wr, input logic [ADDR_W-1:0] addr,
                                 input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb);
        i_req_valid[slot]                  = 1'b1;
        i_req_write[slot]                  = wr;
        i_req_addr[slot*ADDR_W +: ADDR_W]  = addr;
        i_req_wdata[slot*DATA_W +: DATA_W] = wdata;
        i_req_strb[slot*STRB_W +: STRB_W]  = strb;
    endtask

    // Entered and left 1 time unit after a rising edge
    task automatic send_request(input int slot, input logic wr, input logic [ADDR_W-1:0] addr,
                                input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb);
        drive_request(slot, wr, addr, wdata, strb);
        while (!o_req_ready[slot]) begin
            @(posedge i_clk);
            #1;
        end
        @(posedge i_clk);
        #1;
        i_req_valid[slot] = 1'b0;
    endtask

    task automatic take_response(input int slot, output logic [DATA_W-1:0] rdata,
                                 output logic [RESP_W-1:0] resp);
        while (!o_rsp_valid[slot]) begin
            @(posedge i_clk);
            #1;
        end
        rdata             = o_rsp_rdata[slot*DATA_W +: DATA_W];
        resp              = o_rsp_resp[slot*RESP_W +: RESP_W];
        i_rsp_ready[slot] = 1'b1;
        @(posedge i_clk);
        #1;
        i_rsp_ready[slot] = 1'b0;
    endtask

    task automatic write_word(input int slot, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb,
                              input logic [RESP_W-1:0] exp_resp);
        logic [DATA_W-1:0] rdata;
        logic [RESP_W-1:0] resp;
        send_request(slot, 1'b1, addr, data, strb);
        take_response(slot, rdata, resp);
        check_value($sformatf("o_rsp_resp[%0d]", slot), exp_resp, resp);
        if (exp_resp == RESP_OKAY) begin
            ref_mem[addr[9:2]] = merge_bytes(ref_mem[addr[9:2]], data, strb);
        end
    endtask

    task automatic read_word(input int slot, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] exp_data,
                             input logic [RESP_W-1:0] exp_resp);
        logic [DATA_W-1:0] rdata;
        logic [RESP_W-1:0] resp;
        send_request(slot, 1'b0, addr, '0, '0);
        take_response(slot, rdata, resp);
        check_value($sformatf("o_rsp_resp[%0d]", slot), exp_resp, resp);
        check_value($sformatf("o_rsp_rdata[%0d]", slot), exp_data, rdata);
    endtask

    // Both slots request in the same cycle; c0 and c1 are the cycles their responses show up
    task automatic issue_pair(input logic wr0, input logic wr1,
                              input logic [ADDR_W-1:0] a0, input logic [ADDR_W-1:0] a1,
                              input logic [DATA_W-1:0] d1,
                              output logic [DATA_W-1:0] r0, output logic [DATA_W-1:0] r1,
                              output int c0, output int c1);
        c0 = -1;
        c1 = -1;
        drive_request(0, wr0, a0, '0, 4'hF);
        drive_request(1, wr1, a1, d1, 4'hF);
        while (!(o_req_ready[0] && o_req_ready[1])) begin
            @(posedge i_clk);
            #1;
        end
        @(posedge i_clk);
        #1;
        i_req_valid = '0;
        while (c0 < 0 || c1 < 0) begin
            if (c0 < 0 && o_rsp_valid[0]) begin
                c0 = cycles;
                r0 = o_rsp_rdata[DATA_W-1:0];
            end
            if (c1 < 0 && o_rsp_valid[1]) begin
                c1 = cycles;
                r1 = o_rsp_rdata[2*DATA_W-1:DATA_W];
            end
            if (c0 < 0 || c1 < 0) begin
                @(posedge i_clk);
                #1;
            end
        end
        i_rsp_ready = '1;
        @(posedge i_clk);
        #1;
        i_rsp_ready = '0;
    endtask

    task automatic write_read_slot0();
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        repeat (4) begin
            addr = rand_addr();
            data = rand_word();
            write_word(0, addr, data, 4'hF, RESP_OKAY);
            read_word(0, addr, data, RESP_OKAY);
        end
        known_addr = addr;
    endtask

    task automatic partial_strobe_slot1();
        logic [ADDR_W-1:0] addr;
        addr = rand_addr();
        write_word(1, addr, rand_word(), 4'hF, RESP_OKAY);
        write_word(1, addr, rand_word(), 4'b0101, RESP_OKAY);
        read_word(1, addr, ref_mem[addr[9:2]], RESP_OKAY);
        write_word(1, addr, rand_word(), 4'b1000, RESP_OKAY);
        read_word(1, addr, ref_mem[addr[9:2]], RESP_OKAY);
        write_word(1, addr, rand_word(), 4'b0110, RESP_OKAY);
        read_word(1, addr, ref_mem[addr[9:2]], RESP_OKAY);
    endtask

    task automatic out_of_range_access();
        logic [ADDR_W-1:0] bad_addr;
        // Same low index bits as a stored word, so a wrong write would show up there
        bad_addr = known_addr | 16'h0400;
        write_word(0, bad_addr, ~ref_mem[known_addr[9:2]], 4'hF, RESP_SLVERR);
        read_word(1, bad_addr, '0, RESP_SLVERR);
        read_word(0, 16'hFFFC, '0, RESP_SLVERR);
        read_word(0, known_addr, ref_mem[known_addr[9:2]], RESP_OKAY);
    endtask

    task automatic write_priority_order();
        logic [ADDR_W-1:0] a1;
        logic [DATA_W-1:0] d1;
        logic [DATA_W-1:0] r0;
        logic [DATA_W-1:0] r1;
        int                c0;
        int                c1;
        a1 = rand_addr();
        d1 = rand_word();
        issue_pair(1'b0, 1'b1, known_addr, a1, d1, r0, r1, c0, c1);
        // The write goes first, so the read already sees it
        ref_mem[a1[9:2]] = d1;
        check_condition(c1 < c0, "slot 1 write was not answered before slot 0 read");
        check_value("o_rsp_rdata[0]", ref_mem[known_addr[9:2]], r0);
        issue_pair(1'b0, 1'b0, known_addr, a1, '0, r0, r1, c0, c1);
        check_condition(c0 < c1, "slot 0 read was not answered before slot 1 read");
        check_value("o_rsp_rdata[0]", ref_mem[known_addr[9:2]], r0);
        check_value("o_rsp_rdata[1]", ref_mem[a1[9:2]], r1);
    endtask

    task automatic rsp_backpressure();
        logic [DATA_W-1:0] held_data;
        logic [RESP_W-1:0] held_resp;
        logic [ADDR_W-1:0] a1;
        logic [DATA_W-1:0] d1;
        logic              slot1_done;
        send_request(0, 1'b0, known_addr, '0, '0);
        while (!o_rsp_valid[0]) begin
            @(posedge i_clk);
            #1;
        end
        held_data  = o_rsp_rdata[DATA_W-1:0];
        held_resp  = o_rsp_resp[RESP_W-1:0];
        slot1_done = 1'b0;
        a1         = rand_addr();
        d1         = rand_word();
        check_value("o_rsp_rdata[0]", ref_mem[known_addr[9:2]], held_data);
        fork
            begin
                repeat (20) begin
                    @(posedge i_clk);
                    #1;
                    check_condition(o_rsp_valid[0], "slot 0 response valid dropped while held");
                    check_value("o_rsp_rdata[0]", held_data, o_rsp_rdata[DATA_W-1:0]);
                    check_value("o_rsp_resp[0]", held_resp, o_rsp_resp[RESP_W-1:0]);
                    check_condition(!o_req_ready[0], "slot 0 ready while its response waits");
                end
                check_condition(slot1_done, "slot 1 did not finish while slot 0 was held");
            end
            begin
                write_word(1, a1, d1, 4'hF, RESP_OKAY);
                read_word(1, a1, d1, RESP_OKAY);
                slot1_done = 1'b1;
            end
        join
        take_response(0, held_data, held_resp);
        check_value("o_rsp_resp[0]", RESP_OKAY, held_resp);
    endtask

    initial begin
        i_nrst      = 1'b0;
        i_req_valid = '0;
        i_req_write = '0;
        i_req_addr  = '0;
        i_req_wdata = '0;
        i_req_strb  = '0;
        i_rsp_ready = '0;
        rng_state   = 32'd62933;
        repeat (3) @(posedge i_clk);
        #1;
        i_nrst = 1'b1;

        write_read_slot0();
        partial_strobe_slot1();
        out_of_range_access();
        write_priority_order();
        rsp_backpressure();

        $display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: compile.f
src/l2_bus_pkg.sv
src/l1_port_buffer.sv
src/l2_arbiter.sv
src/l2_sram.sv
src/l2_subsystem_top.sv
tests/tb_l2_subsystem.sv
